// File: all.f
+incdir+common
common/pipe_pkg.sv
common/ex_mem_if.sv
mem_stage/ex_mem_reg.sv
mem_stage/data_mem.sv
mem_stage/mem_wb_reg.sv
hw/back_end.sv
verif/tb_back_end.sv

// File: run.sh
#!/bin/sh
# Compile the back end with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module tb_back_end -f all.f -o tb_back_end
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_back_end 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verif/tb_back_end.sv
`include "pipe_consts.svh"

module tb_back_end;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int SEED       = 63869;

    // Test lengths in issued instructions
    localparam int N_ALU     = 40;
    localparam int N_LDST    = 60;
    localparam int N_BRANCH  = 40;
    localparam int N_FLUSH   = 16;     // Three instructions each
    localparam int N_STALL   = 60;
    localparam int N_DRAIN   = 4;
    localparam int MAX_STALL = 3;      // Longest run of stalled edges

    // Small window so loads keep hitting recent stores
    localparam pipe_pkg::dmem_addr_t WIN_BASE = 10'h100;
    localparam int WIN_BYTES  = 32;
    localparam int FILL_WORDS = WIN_BYTES / 4;

    localparam int RUN_CYCLES = RST_CYCLES + N_ALU + FILL_WORDS + N_LDST + N_BRANCH
                              + 3 * N_FLUSH + (MAX_STALL + 1) * N_STALL + N_DRAIN;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 50;

    // One execute-stage result as seen on the DUT inputs
    typedef struct packed {
        pipe_pkg::pc_addr_t  branch_target;
        pipe_pkg::word_t     alu_result;
        pipe_pkg::reg_sel_t  rd;
        logic                alu_zero;
        logic                branch;
        logic                jump;
        logic                mem_read;
        logic                mem_write;
        logic                mem_to_reg;
        logic                reg_write;
        pipe_pkg::word_t     write_data;
        pipe_pkg::mem_size_t data_size;
        logic                data_sign;
    } instr_t;

    logic clk;
    logic rst;
    logic flush;
    logic stall;
    instr_t cur;                                // Currently driven instruction

    logic                redirect;
    pipe_pkg::pc_addr_t  redirect_target;
    logic                wb_en;
    pipe_pkg::reg_sel_t  wb_rd;
    pipe_pkg::word_t     wb_data;

    // Reference model state
    logic [7:0]         model_mem [`PIPE_DMEM_BYTES];
    instr_t             s1;                     // Instruction held in MEM
    logic               exp_wb_en;
    pipe_pkg::reg_sel_t exp_wb_rd;
    pipe_pkg::word_t    exp_wb_data;
    logic               exp_redirect;
    logic               reset_seen = 1'b0;

    logic [31:0] lcg_state;
    string       test_name;

    back_end i_back_end (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .stall           (stall),
        .branch_target   (cur.branch_target),
        .alu_result      (cur.alu_result),
        .rd              (cur.rd),
        .alu_zero        (cur.alu_zero),
        .branch          (cur.branch),
        .jump            (cur.jump),
        .mem_read        (cur.mem_read),
        .mem_write       (cur.mem_write),
        .mem_to_reg      (cur.mem_to_reg),
        .reg_write       (cur.reg_write),
        .write_data      (cur.write_data),
        .data_size       (cur.data_size),
        .data_sign       (cur.data_sign),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .wb_en           (wb_en),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_stop("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // Error reporting and random numbers
    ////////////////////////////////////////////////////////////

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s %s: expected 0x%08h, actual 0x%08h",
                 test_name, what, expected, actual);
        fail_stop("Output differs from the reference model");
    endtask

    // Two LCG steps, upper halves only since low bits cycle fast
    function automatic logic [31:0] next_rand();
        logic [15:0] hi;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        hi = lcg_state[31:16];
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {hi, lcg_state[31:16]};
    endfunction

    function automatic pipe_pkg::mem_size_t rand_size();
        return pipe_pkg::mem_size_t'(next_rand() % 3);
    endfunction

    // Aligned address inside the test window
    function automatic pipe_pkg::dmem_addr_t rand_addr(input pipe_pkg::mem_size_t size);
        pipe_pkg::dmem_addr_t a;
        a = WIN_BASE + pipe_pkg::dmem_addr_t'(next_rand() % WIN_BYTES);
        return a & ~pipe_pkg::dmem_addr_t'((1 << size) - 1);
    endfunction

    function automatic pipe_pkg::word_t fill_word(input pipe_pkg::dmem_addr_t a);
        return {a, 6'h15, a, 6'h2a};            // Whole address in both halves
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction builders
    ////////////////////////////////////////////////////////////

    function automatic instr_t make_alu();
        instr_t s;
        logic [31:0] r;
        r = next_rand();
        s = '0;
        s.alu_result    = next_rand();
        s.branch_target = r[9:0];
        s.rd            = r[14:10];
        s.alu_zero      = r[15];                // No effect without branch
        s.write_data    = next_rand();          // Ignored, no store
        s.reg_write     = 1'b1;
        return s;
    endfunction

    function automatic instr_t make_branch();
        instr_t s;
        logic [31:0] r;
        r = next_rand();
        s = make_alu();
        s.branch    = r[16];
        s.jump      = r[17];
        s.alu_zero  = r[18];
        s.reg_write = r[19];                    // Link write on some jumps
        return s;
    endfunction

    function automatic instr_t make_store(input pipe_pkg::dmem_addr_t addr,
                                          input pipe_pkg::mem_size_t size,
                                          input pipe_pkg::word_t data);
        instr_t s;
        logic [31:0] r;
        r = next_rand();
        s = '0;
        s.alu_result = {r[31:10], addr};        // Upper bits must be ignored
        s.rd         = r[4:0];
        s.write_data = data;
        s.data_size  = size;
        s.mem_write  = 1'b1;
        return s;
    endfunction

    function automatic instr_t make_load(input pipe_pkg::dmem_addr_t addr,
                                         input pipe_pkg::mem_size_t size);
        instr_t s;
        logic [31:0] r;
        r = next_rand();
        s = '0;
        s.alu_result = {r[31:10], addr};
        s.rd         = r[4:0];
        s.data_sign  = r[5];
        s.data_size  = size;
        s.mem_read   = 1'b1;
        s.mem_to_reg = 1'b1;
        s.reg_write  = 1'b1;
        return s;
    endfunction

    function automatic instr_t make_random();
        logic [1:0] kind;
        pipe_pkg::mem_size_t size;
        kind = 2'(next_rand());
        size = rand_size();
        case (kind)
            2'd0: return make_alu();
            2'd1: return make_branch();
            2'd2: return make_store(rand_addr(size), size, next_rand());
            default: return make_load(rand_addr(size), size);
        endcase
    endfunction

    // Drive one instruction, holding it through random stall edges
    task automatic issue(input instr_t s, input logic do_flush, input logic may_stall);
        int   held;
        logic hold;
        @(posedge clk);
        cur   <= s;
        flush <= do_flush;
        hold  = may_stall && !do_flush && (next_rand() % 4 == 0);
        stall <= hold;
        held  = 0;
        while (hold) begin
            @(posedge clk);                     // Stalled edge, inputs unchanged
            held++;
            hold = (held < MAX_STALL) && (next_rand() % 3 == 0);
            stall <= hold;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Little-endian assembly of 1, 2 or 4 bytes, then extension
    function automatic pipe_pkg::word_t load_value(input pipe_pkg::dmem_addr_t addr,
                                                   input pipe_pkg::mem_size_t size,
                                                   input logic sign);
        int nbytes;
        pipe_pkg::dmem_addr_t base;
        pipe_pkg::word_t value;
        nbytes = 1 << size;
        base   = addr & ~pipe_pkg::dmem_addr_t'(nbytes - 1);
        value  = '0;
        for (int i = 0; i < nbytes; i++) begin
            value = value | (pipe_pkg::word_t'(model_mem[base + pipe_pkg::dmem_addr_t'(i)])
                             << (8 * i));
        end
        if (sign && nbytes < 4 && value[8 * nbytes - 1]) begin
            value = value | ((~pipe_pkg::word_t'(0)) << (8 * nbytes));
        end
        return value;
    endfunction

    assign exp_redirect = s1.jump || (s1.branch && s1.alu_zero);

    always @(posedge clk) begin : model_update
        pipe_pkg::dmem_addr_t st_base;
        if (rst) begin
            reset_seen <= 1'b1;
            s1         <= '0;
            exp_wb_en  <= 1'b0;
        end else begin
            // Store lands whenever it sits in MEM, stall or not
            if (s1.mem_write) begin
                st_base = pipe_pkg::dmem_addr_t'(s1.alu_result)
                        & ~pipe_pkg::dmem_addr_t'((1 << s1.data_size) - 1);
                for (int i = 0; i < 4; i++) begin
                    if (i < (1 << s1.data_size)) begin
                        model_mem[st_base + pipe_pkg::dmem_addr_t'(i)] <=
                            s1.write_data[8 * i +: 8];
                    end
                end
            end
            if (!stall) begin                   // WB ignores flush
                exp_wb_en   <= s1.reg_write;
                exp_wb_rd   <= s1.rd;
                exp_wb_data <= s1.mem_to_reg
                    ? load_value(pipe_pkg::dmem_addr_t'(s1.alu_result), s1.data_size,
                                 s1.data_sign)
                    : s1.alu_result;
            end
            if (flush) begin
                s1 <= '0;                       // Bubble, beats stall
            end else if (!stall) begin
                s1 <= cur;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_reset_quiet : assert property (@(posedge clk) rst && reset_seen |-> !redirect && !wb_en)
        else report_mismatch("{redirect,wb_en}", 32'd0,
                             32'({$sampled(redirect), $sampled(wb_en)}));

    a_redirect : assert property (@(posedge clk) disable iff (rst) redirect == exp_redirect)
        else report_mismatch("redirect", 32'($sampled(exp_redirect)), 32'($sampled(redirect)));

    a_redirect_target : assert property (@(posedge clk) disable iff (rst)
        exp_redirect |-> redirect_target == s1.branch_target)
        else report_mismatch("redirect_target", 32'($sampled(s1.branch_target)),
                             32'($sampled(redirect_target)));

    a_wb_en : assert property (@(posedge clk) disable iff (rst) wb_en == exp_wb_en)
        else report_mismatch("wb_en", 32'($sampled(exp_wb_en)), 32'($sampled(wb_en)));

    a_wb_rd : assert property (@(posedge clk) disable iff (rst) exp_wb_en |-> wb_rd == exp_wb_rd)
        else report_mismatch("wb_rd", 32'($sampled(exp_wb_rd)), 32'($sampled(wb_rd)));

    a_wb_data : assert property (@(posedge clk) disable iff (rst)
        exp_wb_en |-> wb_data == exp_wb_data)
        else report_mismatch("wb_data", $sampled(exp_wb_data), $sampled(wb_data));

    // Flushed word becomes a bubble in MEM
    a_flush_no_redirect : assert property (@(posedge clk) disable iff (rst) flush |=> !redirect)
        else fail_stop("A flushed instruction raised redirect");

    a_stall_hold : assert property (@(posedge clk) disable iff (rst)
        stall && !flush |=> $stable(redirect) && $stable(wb_en)
            && (!redirect || $stable(redirect_target))
            && (!wb_en || ($stable(wb_rd) && $stable(wb_data))))
        else fail_stop("Outputs changed while stall was high");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        pipe_pkg::dmem_addr_t addr;
        pipe_pkg::mem_size_t  size;
        instr_t               s;
        rst       = 1'b1;
        flush     = 1'b0;
        stall     = 1'b0;
        cur       = '0;
        lcg_state = SEED;
        test_name = "reset";
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_name = "alu_writeback";
        repeat (N_ALU) issue(make_alu(), 1'b0, 1'b0);

        test_name = "memory_fill";              // Window known before any load
        for (int w = 0; w < FILL_WORDS; w++) begin
            addr = WIN_BASE + pipe_pkg::dmem_addr_t'(4 * w);
            issue(make_store(addr, `PIPE_SIZE_WORD, fill_word(addr)), 1'b0, 1'b0);
        end

        test_name = "load_store";
        for (int n = 0; n < N_LDST; n++) begin
            size = rand_size();
            addr = rand_addr(size);
            if (next_rand() % 2 == 0) begin
                s = make_store(addr, size, next_rand());
            end else begin
                s = make_load(addr, size);
            end
            issue(s, 1'b0, 1'b0);
        end

        test_name = "branch";
        repeat (N_BRANCH) issue(make_branch(), 1'b0, 1'b0);

        test_name = "flush";
        for (int n = 0; n < N_FLUSH; n++) begin
            size = rand_size();
            addr = rand_addr(size);
            issue(make_alu(), 1'b0, 1'b0);      // Ahead of the flush, still retires
            s = make_store(addr, size, next_rand());
            s.jump      = 1'b1;                 // Every effect must vanish
            s.reg_write = 1'b1;
            issue(s, 1'b1, 1'b0);
            issue(make_load(addr, size), 1'b0, 1'b0);
        end

        test_name = "stall";
        repeat (N_STALL) issue(make_random(), 1'b0, 1'b1);

        test_name = "drain";
        repeat (N_DRAIN) issue('0, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: hw/back_end.sv
module back_end (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                stall,

    // Execute stage results
    input  pipe_pkg::pc_addr_t  branch_target,
    input  pipe_pkg::word_t     alu_result,
    input  pipe_pkg::reg_sel_t  rd,

    input  logic                alu_zero,
    input  logic                branch,
    input  logic                jump,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                reg_write,

    input  pipe_pkg::word_t     write_data,
    input  pipe_pkg::mem_size_t data_size,
    input  logic                data_sign,

    // PC redirect, one cycle after issue
    output logic                redirect,
    output pipe_pkg::pc_addr_t  redirect_target,

    // Register file write port, two cycles after issue
    output logic                wb_en,
    output pipe_pkg::reg_sel_t  wb_rd,
    output pipe_pkg::word_t     wb_data
);

    ex_mem_if ex_mem ();

    pipe_pkg::word_t load_data;     // data_mem -> mem_wb_reg

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    ex_mem_reg i_ex_mem_reg (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .stall         (stall),
        .branch_target (branch_target),
        .alu_result    (alu_result),
        .rd            (rd),
        .alu_zero      (alu_zero),
        .branch        (branch),
        .jump          (jump),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .write_data    (write_data),
        .data_size     (data_size),
        .data_sign     (data_sign),
        .ex_mem        (ex_mem.producer)
    );

    ////////////////////////////////////////////////////////////
    // Memory stage
    ////////////////////////////////////////////////////////////

    data_mem i_data_mem (
        .clk       (clk),
        .ex_mem    (ex_mem.consumer),
        .load_data (load_data)
    );

    // Taken on any jump, or on a branch whose compare came out zero
    assign redirect        = ex_mem.jump || (ex_mem.branch && ex_mem.alu_zero);
    assign redirect_target = ex_mem.branch_target;  // Hazard unit decides on flush

    ////////////////////////////////////////////////////////////
    // MEM/WB register and write-back select
    ////////////////////////////////////////////////////////////

    mem_wb_reg i_mem_wb_reg (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .ex_mem    (ex_mem.consumer),
        .load_data (load_data),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

// File: mem_stage/mem_wb_reg.sv
module mem_wb_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,        // Hold, flush does not reach here
    ex_mem_if.consumer          ex_mem,
    input  pipe_pkg::word_t     load_data,    // From data_mem, combinational

    output logic                wb_en,
    output pipe_pkg::reg_sel_t  wb_rd,
    output pipe_pkg::word_t     wb_data
);

    ////////////////////////////////////////////////////////////
    // Write-back source select
    ////////////////////////////////////////////////////////////

    pipe_pkg::word_t wb_src;

    // Only the chosen value is kept, WB is then just this register
    assign wb_src = ex_mem.mem_to_reg ? load_data : ex_mem.alu_result;

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else if (!stall) begin
            wb_en <= ex_mem.reg_write;      // Bubble retires as no write
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_rd   <= ex_mem.rd;
            wb_data <= wb_src;
        end
    end

    // Load result selected only for an actual load
    a_mem_to_reg_needs_read : assert property (@(posedge clk) disable iff (rst)
        !stall && ex_mem.reg_write && ex_mem.mem_to_reg |-> ex_mem.mem_read)
        else $error("mem_wb_reg: mem_to_reg captured without mem_read, rd=%0d", ex_mem.rd);

endmodule

// File: mem_stage/data_mem.sv
`include "pipe_consts.svh"

module data_mem (
    input  logic              clk,
    ex_mem_if.consumer        ex_mem,
    output pipe_pkg::word_t   load_data     // Valid only with mem_read
);

    localparam int AW = $bits(pipe_pkg::dmem_addr_t);

    logic [7:0] mem_bytes [`PIPE_DMEM_BYTES];   // No reset, contents persist

    ////////////////////////////////////////////////////////////
    // Lane addresses
    ////////////////////////////////////////////////////////////

    pipe_pkg::dmem_addr_t byte_addr;
    pipe_pkg::dmem_addr_t half_lane [2];        // Bit 0 forced per lane
    pipe_pkg::dmem_addr_t word_lane [4];        // Bits 1:0 forced per lane

    assign byte_addr = pipe_pkg::dmem_addr_t'(ex_mem.alu_result);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            half_lane[i] = {byte_addr[AW-1:1], 1'(i)};
        end
        for (int i = 0; i < 4; i++) begin
            word_lane[i] = {byte_addr[AW-1:2], 2'(i)};
        end
    end

    ////////////////////////////////////////////////////////////
    // Sized store, little-endian
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ex_mem.mem_write) begin         // Repeats harmlessly under stall
            case (ex_mem.data_size)
                `PIPE_SIZE_BYTE: begin
                    mem_bytes[byte_addr] <= ex_mem.write_data[7:0];
                end
                `PIPE_SIZE_HALF: begin
                    mem_bytes[half_lane[0]] <= ex_mem.write_data[7:0];
                    mem_bytes[half_lane[1]] <= ex_mem.write_data[15:8];
                end
                `PIPE_SIZE_WORD: begin
                    mem_bytes[word_lane[0]] <= ex_mem.write_data[7:0];
                    mem_bytes[word_lane[1]] <= ex_mem.write_data[15:8];
                    mem_bytes[word_lane[2]] <= ex_mem.write_data[23:16];
                    mem_bytes[word_lane[3]] <= ex_mem.write_data[31:24];
                end
                default: begin
                    // Illegal size, nothing written
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Load with sign or zero extension
    ////////////////////////////////////////////////////////////

    logic [7:0]      rd_byte;
    logic [15:0]     rd_half;
    pipe_pkg::word_t rd_word;

    assign rd_byte = mem_bytes[byte_addr];
    assign rd_half = {mem_bytes[half_lane[1]], mem_bytes[half_lane[0]]};
    assign rd_word = {mem_bytes[word_lane[3]], mem_bytes[word_lane[2]],
                      mem_bytes[word_lane[1]], mem_bytes[word_lane[0]]};

    always_comb begin
        case (ex_mem.data_size)
            `PIPE_SIZE_BYTE:
                load_data = {{(`PIPE_WORD_SIZE-8){ex_mem.data_sign & rd_byte[7]}}, rd_byte};
            `PIPE_SIZE_HALF:
                load_data = {{(`PIPE_WORD_SIZE-16){ex_mem.data_sign & rd_half[15]}}, rd_half};
            default:
                load_data = rd_word;        // Word, sign flag has no effect
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Alignment, low bits are dropped rather than trapped
    ////////////////////////////////////////////////////////////

    a_half_aligned : assert property (@(posedge clk)
        (ex_mem.mem_read || ex_mem.mem_write) && ex_mem.data_size == `PIPE_SIZE_HALF
            |-> byte_addr[0] == 1'b0)
        else $error("data_mem: misaligned halfword access at 0x%h", byte_addr);

    a_word_aligned : assert property (@(posedge clk)
        (ex_mem.mem_read || ex_mem.mem_write) && ex_mem.data_size == `PIPE_SIZE_WORD
            |-> byte_addr[1:0] == 2'b00)
        else $error("data_mem: misaligned word access at 0x%h", byte_addr);

endmodule

// File: mem_stage/ex_mem_reg.sv
`include "pipe_consts.svh"

module ex_mem_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,            // Load a bubble, beats stall
    input  logic                stall,            // Hold current contents

    input  pipe_pkg::pc_addr_t  branch_target,
    input  pipe_pkg::word_t     alu_result,
    input  pipe_pkg::reg_sel_t  rd,

    input  logic                alu_zero,
    input  logic                branch,
    input  logic                jump,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                mem_to_reg,
    input  logic                reg_write,

    input  pipe_pkg::word_t     write_data,
    input  pipe_pkg::mem_size_t data_size,
    input  logic                data_sign,

    ex_mem_if.producer          ex_mem
);

    ////////////////////////////////////////////////////////////
    // Control bits, cleared on reset and on flush
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem.branch     <= 1'b0;
            ex_mem.jump       <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.reg_write  <= 1'b0;
        end else if (flush) begin           // Bubble
            ex_mem.branch     <= 1'b0;
            ex_mem.jump       <= 1'b0;
            ex_mem.mem_read   <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.reg_write  <= 1'b0;
        end else if (!stall) begin
            ex_mem.branch     <= branch;
            ex_mem.jump       <= jump;
            ex_mem.mem_read   <= mem_read;
            ex_mem.mem_write  <= mem_write;
            ex_mem.mem_to_reg <= mem_to_reg;
            ex_mem.reg_write  <= reg_write;
        end
    end

    // Payload, meaningless while controls are low
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_mem.branch_target <= branch_target;
            ex_mem.alu_result    <= alu_result;
            ex_mem.rd            <= rd;
            ex_mem.alu_zero      <= alu_zero;      // Only qualifies branch
            ex_mem.write_data    <= write_data;
            ex_mem.data_size     <= data_size;
            ex_mem.data_sign     <= data_sign;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks on each captured instruction
    ////////////////////////////////////////////////////////////

    // A captured word never both loads and stores
    a_no_rw_conflict : assert property (@(posedge clk) disable iff (rst)
        !stall && !flush |=> !(ex_mem.mem_read && ex_mem.mem_write))
        else $error("ex_mem_reg: mem_read and mem_write both captured");

    // Memory access carries a legal size code
    a_legal_size : assert property (@(posedge clk) disable iff (rst)
        !stall && !flush |=> !(ex_mem.mem_read || ex_mem.mem_write)
            || ex_mem.data_size inside {`PIPE_SIZE_BYTE, `PIPE_SIZE_HALF, `PIPE_SIZE_WORD})
        else $error("ex_mem_reg: illegal data_size %0d captured", ex_mem.data_size);

endmodule

// File: common/ex_mem_if.sv
// EX/MEM register outputs, all fields are levels valid every cycle
interface ex_mem_if;

    pipe_pkg::pc_addr_t  branch_target;    // Resolved target PC
    pipe_pkg::word_t     alu_result;       // ALU output, also the memory address
    pipe_pkg::reg_sel_t  rd;               // Write-back register

    // Branch qualifiers
    logic alu_zero;
    logic branch;
    logic jump;

    // Memory and write-back control, all low in a bubble
    logic mem_read;
    logic mem_write;
    logic mem_to_reg;
    logic reg_write;

    // Store data and access shape
    pipe_pkg::word_t     write_data;
    pipe_pkg::mem_size_t data_size;
    logic                data_sign;        // 1 sign-extends loads

    // Pipeline register side
    modport producer (
        output branch_target, alu_result, rd,
        output alu_zero, branch, jump,
        output mem_read, mem_write, mem_to_reg, reg_write,
        output write_data, data_size, data_sign
    );

    // Memory, write-back and redirect side
    modport consumer (
        input branch_target, alu_result, rd,
        input alu_zero, branch, jump,
        input mem_read, mem_write, mem_to_reg, reg_write,
        input write_data, data_size, data_sign
    );

endinterface

// File: common/pipe_pkg.sv
`include "pipe_consts.svh"

// Types shared by the memory and write-back stages
package pipe_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath values
    ////////////////////////////////////////////////////////////

    // One integer data word
    typedef logic [`PIPE_WORD_SIZE-1:0] word_t;

    // Branch or jump target PC
    typedef logic [`PIPE_ADDR_SIZE-1:0] pc_addr_t;

    ////////////////////////////////////////////////////////////
    // Memory and register selection
    ////////////////////////////////////////////////////////////

    // Byte address into data memory
    typedef logic [$clog2(`PIPE_DMEM_BYTES)-1:0] dmem_addr_t;

    // Destination register index
    typedef logic [$clog2(`PIPE_NUM_REGS)-1:0] reg_sel_t;

    // Load/store size code, see PIPE_SIZE_* in pipe_consts.svh
    typedef logic [1:0] mem_size_t;

endpackage

// File: common/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define PIPE_WORD_SIZE  32      // Integer datapath width
`define PIPE_NUM_REGS   32      // Register file entries
`define PIPE_ADDR_SIZE  10      // Instruction address width

// Data memory depth in bytes, byte address is alu_result[9:0]
`define PIPE_DMEM_BYTES 1024

// Access size codes, 2'd3 is illegal
`define PIPE_SIZE_BYTE  2'd0
`define PIPE_SIZE_HALF  2'd1
`define PIPE_SIZE_WORD  2'd2

`endif
